// File: hw/wb_pkg.sv
/* Wishbone field types for the host port and the internal target links */
package wb_pkg;

    // Byte address, full 32 bits from the host
    typedef logic [31:0] wb_addr_t;

    // Data word in both directions
    typedef logic [31:0] wb_data_t;

    // One enable per byte lane of wb_data_t
    typedef logic [3:0] wb_sel_t;

    // Lanes are 8 bits wide
    localparam int unsigned WB_LANE_W = 8;

endpackage

// File: hw/soc_cfg_pkg.sv
/* Chip-level configuration of the user-area hub: address map, team count, pin widths.
   Shared by the decoder, the select registers and the scratch SRAM. */
package soc_cfg_pkg;

    localparam int unsigned NUM_DESIGNS = 4;    // Team designs behind the pin mux

    // Pin and analyzer widths
    localparam int unsigned GPIO_W = 38;
    localparam int unsigned LA_W   = 128;
    typedef logic [GPIO_W-1:0] gpio_t;
    typedef logic [LA_W-1:0]   la_t;

    // Team index, NO_DESIGN parks the outputs
    typedef logic [2:0] design_idx_t;
    localparam design_idx_t NO_DESIGN = 3'd7;

    // Region field is address bits 31..16
    typedef logic [15:0] region_t;
    localparam region_t REGION_SRAM   = 16'h3000;
    localparam region_t REGION_SELECT = 16'h3001;

    localparam int unsigned SRAM_WORDS = 256;
    typedef logic [$clog2(SRAM_WORDS)-1:0] sram_idx_t;  // Word index from address bits 9..2

    // Select register byte offsets, only bit 2 is decoded
    localparam logic [2:0] SEL_GPIO_OFS = 3'd0;
    localparam logic [2:0] SEL_LA_OFS   = 3'd4;

endpackage

// File: hw/wb_if.sv
/* One Wishbone classic link between the address decoder and a single target.
   The decoder takes the initiator side, each target the target side. */
`timescale 1ns/100ps

interface wb_if;

    logic             cyc;
    logic             stb;
    logic             we;
    wb_pkg::wb_sel_t  sel;
    wb_pkg::wb_addr_t adr;
    wb_pkg::wb_data_t dat_w;    // Write data toward the target
    wb_pkg::wb_data_t dat_r;    // Read data, valid with ack
    logic             ack;

    // Decoder side
    modport initiator (
        output cyc, stb, we, sel, adr, dat_w,
        input  dat_r, ack
    );

    // Target side
    modport target (
        input  cyc, stb, we, sel, adr, dat_w,
        output dat_r, ack
    );

endinterface

// File: hw/wb_address_decoder.sv
/* Splits host Wishbone cycles between the scratch SRAM and the select registers.
   Unmapped space is answered here with a one-cycle ack and zero data. */
`timescale 1ns/100ps

module wb_address_decoder (
    input  logic             wb_clk_i,
    input  logic             rst_n_i,

    // Host side
    input  logic             cyc_i,
    input  logic             stb_i,
    input  logic             we_i,
    input  wb_pkg::wb_sel_t  sel_i,
    input  wb_pkg::wb_addr_t adr_i,
    input  wb_pkg::wb_data_t dat_i,
    output logic             ack_o,
    output wb_pkg::wb_data_t dat_o,

    // Target links
    wb_if.initiator          sram_o,
    wb_if.initiator          select_o
);

    soc_cfg_pkg::region_t region;
    logic                 hit_sram;
    logic                 hit_select;
    logic                 hit_none;
    logic                 none_ack;     // Own ack for unmapped space

    assign region     = adr_i[$bits(wb_pkg::wb_addr_t)-1 -: $bits(soc_cfg_pkg::region_t)];
    assign hit_sram   = (region == soc_cfg_pkg::REGION_SRAM);
    assign hit_select = (region == soc_cfg_pkg::REGION_SELECT);
    assign hit_none   = !hit_sram && !hit_select;

    // Request fields fan out to both links, only one sees the strobe
    assign sram_o.cyc   = cyc_i & hit_sram;
    assign sram_o.stb   = stb_i & hit_sram;
    assign sram_o.we    = we_i;
    assign sram_o.sel   = sel_i;
    assign sram_o.adr   = adr_i;
    assign sram_o.dat_w = dat_i;

    assign select_o.cyc   = cyc_i & hit_select;
    assign select_o.stb   = stb_i & hit_select;
    assign select_o.we    = we_i;
    assign select_o.sel   = sel_i;
    assign select_o.adr   = adr_i;
    assign select_o.dat_w = dat_i;

    // Same one-cycle response as the real targets
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            none_ack <= 1'b0;
        end else begin
            none_ack <= cyc_i & stb_i & hit_none & ~none_ack;
        end
    end

    // Response return, keyed on the address the host still holds
    always_comb begin
        if (hit_sram) begin
            ack_o = sram_o.ack;
            dat_o = sram_o.dat_r;
        end else if (hit_select) begin
            ack_o = select_o.ack;
            dat_o = select_o.dat_r;
        end else begin
            ack_o = none_ack;
            dat_o = '0;     // Unmapped reads as zero
        end
    end

endmodule

// File: hw/team_select_regs.sv
/* Team select registers and the GPIO / logic analyzer output muxes they drive.
   An index outside the team range parks the pins as inputs and zeroes the analyzer. */
`timescale 1ns/100ps

module team_select_regs (
    input  logic                 wb_clk_i,
    input  logic                 rst_n_i,
    wb_if.target                 bus_i,

    // Team outputs, one word per design
    input  soc_cfg_pkg::gpio_t [soc_cfg_pkg::NUM_DESIGNS-1:0] designs_gpio_out_i,
    input  soc_cfg_pkg::gpio_t [soc_cfg_pkg::NUM_DESIGNS-1:0] designs_gpio_oeb_i,
    input  soc_cfg_pkg::la_t   [soc_cfg_pkg::NUM_DESIGNS-1:0] designs_la_i,

    output soc_cfg_pkg::gpio_t   io_out_o,
    output soc_cfg_pkg::gpio_t   io_oeb_o,
    output soc_cfg_pkg::la_t     la_data_out_o
);

    soc_cfg_pkg::design_idx_t gpio_sel;
    soc_cfg_pkg::design_idx_t la_sel;
    logic                     req;
    logic                     wr_en;
    logic                     hit_gpio;
    logic                     hit_la;

    assign req      = bus_i.cyc & bus_i.stb & ~bus_i.ack;
    assign wr_en    = req & bus_i.we & bus_i.sel[0];    // Lane 0 holds the index
    assign hit_gpio = (bus_i.adr[2] == soc_cfg_pkg::SEL_GPIO_OFS[2]);
    assign hit_la   = (bus_i.adr[2] == soc_cfg_pkg::SEL_LA_OFS[2]);

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            gpio_sel  <= soc_cfg_pkg::NO_DESIGN;
            la_sel    <= soc_cfg_pkg::NO_DESIGN;
            bus_i.ack <= 1'b0;
        end else begin
            bus_i.ack <= req;
            if (wr_en && hit_gpio) gpio_sel <= bus_i.dat_w[$bits(gpio_sel)-1:0];
            if (wr_en && hit_la)   la_sel   <= bus_i.dat_w[$bits(la_sel)-1:0];
        end
    end

    // Readback, zero-extended
    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            bus_i.dat_r <= hit_la ? wb_pkg::wb_data_t'(la_sel) : wb_pkg::wb_data_t'(gpio_sel);
        end
    end

    always_comb begin
        if (gpio_sel < soc_cfg_pkg::NUM_DESIGNS) begin
            io_out_o = designs_gpio_out_i[gpio_sel];
            io_oeb_o = designs_gpio_oeb_i[gpio_sel];
        end else begin
            io_out_o = '0;
            io_oeb_o = '1;      // Parked as inputs
        end
    end

    assign la_data_out_o = (la_sel < soc_cfg_pkg::NUM_DESIGNS) ? designs_la_i[la_sel] : '0;

endmodule

// File: hw/scratch_sram.sv
/* Scratch word memory on the host bus with per-byte write enables.
   Read data and ack are registered, one cycle after the strobe. */
`timescale 1ns/100ps

module scratch_sram (
    input  logic wb_clk_i,
    input  logic rst_n_i,
    wb_if.target bus_i
);

    wb_pkg::wb_data_t       mem [soc_cfg_pkg::SRAM_WORDS];
    soc_cfg_pkg::sram_idx_t idx;
    logic                   req;

    // Word index from bits 9..2, upper bits alias
    assign idx = bus_i.adr[$bits(soc_cfg_pkg::sram_idx_t)+1:2];
    assign req = bus_i.cyc & bus_i.stb & ~bus_i.ack;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            bus_i.ack <= 1'b0;
        end else begin
            bus_i.ack <= req;
        end
    end

    // Contents and read data
    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            if (bus_i.we) begin
                for (int b = 0; b < $bits(wb_pkg::wb_sel_t); b++) begin
                    if (bus_i.sel[b]) begin
                        mem[idx][b*wb_pkg::WB_LANE_W +: wb_pkg::WB_LANE_W] <=
                            bus_i.dat_w[b*wb_pkg::WB_LANE_W +: wb_pkg::WB_LANE_W];
                    end
                end
            end
            bus_i.dat_r <= mem[idx];    // Old word on a write, unused by the host
        end
    end

endmodule

// File: hw/nebula_ii.sv
/* Top of the user-area hub: management Wishbone port, address decoder, scratch SRAM
   and the team select block that routes one team's pins and analyzer outputs. */
`timescale 1ns/100ps

module nebula_ii (
    input  logic                 wb_clk_i,
    input  logic                 rst_n_i,

    // Management core Wishbone port
    input  logic                 wbs_cyc_i,
    input  logic                 wbs_stb_i,
    input  logic                 wbs_we_i,
    input  wb_pkg::wb_sel_t      wbs_sel_i,
    input  wb_pkg::wb_addr_t     wbs_adr_i,
    input  wb_pkg::wb_data_t     wbs_dat_i,
    output logic                 wbs_ack_o,
    output wb_pkg::wb_data_t     wbs_dat_o,

    // Team outputs, design 0 in the low word
    input  soc_cfg_pkg::gpio_t [soc_cfg_pkg::NUM_DESIGNS-1:0] designs_gpio_out_i,
    input  soc_cfg_pkg::gpio_t [soc_cfg_pkg::NUM_DESIGNS-1:0] designs_gpio_oeb_i,
    input  soc_cfg_pkg::la_t   [soc_cfg_pkg::NUM_DESIGNS-1:0] designs_la_i,

    // Chip pins and analyzer
    output soc_cfg_pkg::gpio_t   io_out_o,
    output soc_cfg_pkg::gpio_t   io_oeb_o,     // Active low output enable
    output soc_cfg_pkg::la_t     la_data_out_o
);

    wb_if sram_bus ();
    wb_if select_bus ();

    wb_address_decoder u_decoder (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .cyc_i    (wbs_cyc_i),
        .stb_i    (wbs_stb_i),
        .we_i     (wbs_we_i),
        .sel_i    (wbs_sel_i),
        .adr_i    (wbs_adr_i),
        .dat_i    (wbs_dat_i),
        .ack_o    (wbs_ack_o),
        .dat_o    (wbs_dat_o),
        .sram_o   (sram_bus.initiator),
        .select_o (select_bus.initiator)
    );

    team_select_regs u_select (
        .wb_clk_i           (wb_clk_i),
        .rst_n_i            (rst_n_i),
        .bus_i              (select_bus.target),
        .designs_gpio_out_i (designs_gpio_out_i),
        .designs_gpio_oeb_i (designs_gpio_oeb_i),
        .designs_la_i       (designs_la_i),
        .io_out_o           (io_out_o),
        .io_oeb_o           (io_oeb_o),
        .la_data_out_o      (la_data_out_o)
    );

    scratch_sram u_sram (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .bus_i    (sram_bus.target)
    );

endmodule

// File: testbench/nebula_ii_assertions.sv
/* Protocol and reset checks on the hub top level, attached to every nebula_ii by bind. */
`timescale 1ns/100ps

module nebula_ii_assertions (
    input logic               wb_clk_i,
    input logic               rst_n_i,
    input logic               cyc_i,
    input logic               stb_i,
    input logic               ack_i,
    input soc_cfg_pkg::gpio_t oeb_i
);

    // Every ack answers a strobe seen one cycle earlier
    ack_follows_strobe: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        ack_i |-> $past(cyc_i && stb_i))
        else $error("ack raised without cyc and stb in the previous cycle");

    new_strobe_acked: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        $rose(cyc_i && stb_i) |=> ack_i)
        else $error("new strobe was not acked on the next cycle");

    ack_single_cycle: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
        else $error("ack stayed high for two cycles");

    // Pins parked as inputs while reset is applied
    oeb_parked_in_reset: assert property (@(posedge wb_clk_i)
        !rst_n_i |=> (oeb_i == '1))
        else $error("io_oeb_o not all ones during reset");

endmodule

bind nebula_ii nebula_ii_assertions u_assertions (
    .wb_clk_i (wb_clk_i),
    .rst_n_i  (rst_n_i),
    .cyc_i    (wbs_cyc_i),
    .stb_i    (wbs_stb_i),
    .ack_i    (wbs_ack_o),
    .oeb_i    (io_oeb_o)
);

// File: testbench/tb_nebula_ii.sv
/* Testbench for the user-area hub: drives the host Wishbone port and the team outputs,
   checks SRAM, select registers, pin routing and unmapped space against a local model. */
`timescale 1ns/100ps

module tb_nebula_ii;

    localparam int unsigned TIMEOUT_CYCLES = 2000;
    localparam int unsigned SRAM_TESTS     = 8;
    localparam wb_pkg::wb_addr_t GPIO_SEL_ADR =
        {soc_cfg_pkg::REGION_SELECT, 13'd0, soc_cfg_pkg::SEL_GPIO_OFS};
    localparam wb_pkg::wb_addr_t LA_SEL_ADR =
        {soc_cfg_pkg::REGION_SELECT, 13'd0, soc_cfg_pkg::SEL_LA_OFS};

    logic             clk;
    logic             rst_n;
    logic             wbs_cyc;
    logic             wbs_stb;
    logic             wbs_we;
    wb_pkg::wb_sel_t  wbs_sel;
    wb_pkg::wb_addr_t wbs_adr;
    wb_pkg::wb_data_t wbs_dat_w;
    wb_pkg::wb_data_t wbs_dat_r;
    logic             wbs_ack;

    soc_cfg_pkg::gpio_t [soc_cfg_pkg::NUM_DESIGNS-1:0] team_gpio_out;
    soc_cfg_pkg::gpio_t [soc_cfg_pkg::NUM_DESIGNS-1:0] team_gpio_oeb;
    soc_cfg_pkg::la_t   [soc_cfg_pkg::NUM_DESIGNS-1:0] team_la;
    soc_cfg_pkg::gpio_t io_out;
    soc_cfg_pkg::gpio_t io_oeb;
    soc_cfg_pkg::la_t   la_out;

    // Reference model
    wb_pkg::wb_data_t         sram_model [soc_cfg_pkg::SRAM_WORDS];
    soc_cfg_pkg::design_idx_t gpio_model;
    soc_cfg_pkg::design_idx_t la_model;
    wb_pkg::wb_addr_t         test_adr [SRAM_TESTS];

    logic [31:0] lfsr_state;
    int unsigned cycle_count;

    nebula_ii UUT (
        .wb_clk_i           (clk),
        .rst_n_i            (rst_n),
        .wbs_cyc_i          (wbs_cyc),
        .wbs_stb_i          (wbs_stb),
        .wbs_we_i           (wbs_we),
        .wbs_sel_i          (wbs_sel),
        .wbs_adr_i          (wbs_adr),
        .wbs_dat_i          (wbs_dat_w),
        .wbs_ack_o          (wbs_ack),
        .wbs_dat_o          (wbs_dat_r),
        .designs_gpio_out_i (team_gpio_out),
        .designs_gpio_oeb_i (team_gpio_oeb),
        .designs_la_i       (team_la),
        .io_out_o           (io_out),
        .io_oeb_o           (io_oeb),
        .la_data_out_o      (la_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Ends a hung run
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("tests failed");
        $fatal(1, "Timeout after %0d cycles without reaching the end of the tests",
               TIMEOUT_CYCLES);
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] random_bits(input int unsigned n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic wb_pkg::wb_data_t merge_lanes(input wb_pkg::wb_data_t old_w,
                                                     input wb_pkg::wb_data_t new_w,
                                                     input wb_pkg::wb_sel_t  sel);
        wb_pkg::wb_data_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) r[8*b +: 8] = new_w[8*b +: 8];
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("tests failed");
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            $fatal(1, "Stopped at the first failed check");
        end
    endtask

    // Ack is sampled on the falling edge, away from the update edge
    task automatic wait_ack();
        do @(negedge clk); while (!wbs_ack);
    endtask

    task automatic bus_write(input wb_pkg::wb_addr_t adr, input wb_pkg::wb_data_t dat,
                             input wb_pkg::wb_sel_t sel);
        @(posedge clk);
        wbs_cyc   <= 1'b1;
        wbs_stb   <= 1'b1;
        wbs_we    <= 1'b1;
        wbs_sel   <= sel;
        wbs_adr   <= adr;
        wbs_dat_w <= dat;
        wait_ack();
        @(posedge clk);
        wbs_cyc <= 1'b0;
        wbs_stb <= 1'b0;
        wbs_we  <= 1'b0;
    endtask

    task automatic bus_read(input wb_pkg::wb_addr_t adr, output wb_pkg::wb_data_t dat);
        @(posedge clk);
        wbs_cyc <= 1'b1;
        wbs_stb <= 1'b1;
        wbs_we  <= 1'b0;
        wbs_sel <= 4'hf;
        wbs_adr <= adr;
        wait_ack();
        dat = wbs_dat_r;
        @(posedge clk);
        wbs_cyc <= 1'b0;
        wbs_stb <= 1'b0;
    endtask

    // Pins and analyzer against the select copies
    task automatic check_pins(input string name);
        soc_cfg_pkg::gpio_t exp_out;
        soc_cfg_pkg::gpio_t exp_oeb;
        soc_cfg_pkg::la_t   exp_la;
        @(negedge clk);
        exp_out = '0;
        exp_oeb = '1;
        exp_la  = '0;
        if (gpio_model < soc_cfg_pkg::NUM_DESIGNS) begin
            exp_out = team_gpio_out[gpio_model];
            exp_oeb = team_gpio_oeb[gpio_model];
        end
        if (la_model < soc_cfg_pkg::NUM_DESIGNS) exp_la = team_la[la_model];
        check_value({name, "_out"}, exp_out, io_out);
        check_value({name, "_oeb"}, exp_oeb, io_oeb);
        check_value({name, "_la"}, exp_la, la_out);
    endtask

    task automatic check_selects(input string name);
        wb_pkg::wb_data_t rd;
        bus_read(GPIO_SEL_ADR, rd);
        check_value({name, "_gpio_sel"}, gpio_model, rd);
        bus_read(LA_SEL_ADR, rd);
        check_value({name, "_la_sel"}, la_model, rd);
    endtask

    task automatic route_gpio(input soc_cfg_pkg::design_idx_t idx);
        bus_write(GPIO_SEL_ADR, idx, 4'h1);
        gpio_model = idx;
        check_pins("gpio_routing");
    endtask

    task automatic route_la(input soc_cfg_pkg::design_idx_t idx, input wb_pkg::wb_sel_t sel);
        bus_write(LA_SEL_ADR, idx, sel);
        if (sel[0]) la_model = idx;     // Index lives in byte lane 0
        check_pins("la_routing");
    endtask

    initial begin
        wb_pkg::wb_data_t wdat;
        wb_pkg::wb_data_t rd;
        wb_pkg::wb_sel_t  wsel;
        wb_pkg::wb_addr_t unmapped_adr;
        lfsr_state = 32'h5fd8_1e4d;
        gpio_model = soc_cfg_pkg::NO_DESIGN;
        la_model   = soc_cfg_pkg::NO_DESIGN;
        rst_n     <= 1'b0;
        wbs_cyc   <= 1'b0;
        wbs_stb   <= 1'b0;
        wbs_we    <= 1'b0;
        wbs_sel   <= '0;
        wbs_adr   <= '0;
        wbs_dat_w <= '0;
        for (int d = 0; d < soc_cfg_pkg::NUM_DESIGNS; d++) begin
            team_gpio_out[d] <= {6'(random_bits(6)), random_bits(32)};
            team_gpio_oeb[d] <= {6'(random_bits(6)), random_bits(32)};
            team_la[d]       <= {random_bits(32), random_bits(32), random_bits(32),
                                 random_bits(32)};
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state
        @(negedge clk);
        check_value("reset_ack", 1'b0, wbs_ack);
        check_pins("reset_pins");
        check_selects("reset");

        // SRAM, full words first so every lane is known, then random lanes
        for (int i = 0; i < SRAM_TESTS; i++) begin
            test_adr[i] = {soc_cfg_pkg::REGION_SRAM, 6'(random_bits(6)), 8'(random_bits(8)),
                           2'b00};
            wdat = random_bits(32);
            bus_write(test_adr[i], wdat, 4'hf);
            sram_model[test_adr[i][9:2]] = wdat;
        end
        for (int i = 0; i < SRAM_TESTS; i++) begin
            wdat = random_bits(32);
            wsel = 4'(random_bits(4));
            bus_write(test_adr[i], wdat, wsel);
            sram_model[test_adr[i][9:2]] = merge_lanes(sram_model[test_adr[i][9:2]], wdat, wsel);
        end
        for (int i = 0; i < SRAM_TESTS; i++) begin
            bus_read(test_adr[i], rd);
            check_value("sram_byte_select", sram_model[test_adr[i][9:2]], rd);
        end

        // GPIO routing, then the parked indices
        for (int d = 0; d < soc_cfg_pkg::NUM_DESIGNS; d++) route_gpio(3'(d));
        route_gpio(3'd5);
        route_gpio(3'd7);

        for (int d = 0; d < soc_cfg_pkg::NUM_DESIGNS; d++) route_la(3'(d), 4'hf);
        route_la(3'd5, 4'h1);
        route_la(3'd2, 4'h1);
        route_la(3'd1, 4'b1110);    // Lane 0 off, select must hold
        check_selects("la_lane0_off");

        // Unmapped space acks and reads zero
        // Low bits alias the first SRAM word and the GPIO select offset
        unmapped_adr = {16'h2000, test_adr[0][15:0]};
        wdat         = ~sram_model[test_adr[0][9:2]];
        wdat[2:0]    = 3'd1;        // A team index other than the current one
        bus_write(unmapped_adr, wdat, 4'hf);
        bus_read(unmapped_adr, rd);
        check_value("unmapped_read", 32'h0, rd);
        bus_read(32'h3002_0000, rd);
        check_value("unmapped_near_select", 32'h0, rd);
        bus_read(test_adr[0], rd);
        check_value("unmapped_sram_intact", sram_model[test_adr[0][9:2]], rd);
        check_selects("unmapped_selects_intact");
        check_pins("unmapped_pins_intact");

        $display("all tests passed");
        $finish;
    end

endmodule

// File: files.f
hw/wb_pkg.sv
hw/soc_cfg_pkg.sv
hw/wb_if.sv
hw/wb_address_decoder.sv
hw/team_select_regs.sv
hw/scratch_sram.sv
hw/nebula_ii.sv
testbench/nebula_ii_assertions.sv
testbench/tb_nebula_ii.sv

// File: Makefile
# Verilator build of the hub testbench; the run target fails when the simulation fails

TOP = tb_nebula_ii

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
